/* run.sh */
#!/bin/sh
# build and run the scheduler testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f sim.f --top-module tbTop -o simTop
./obj_dir/simTop | tee sim.log

# the testbench prints its fail message on any error or timeout
if grep -q "Some tests failed" sim.log; then
	echo "simulation FAILED"
	exit 1
fi
echo "simulation ok"

/* sim.f */
+incdir+source
source/schedPkg.sv
source/packetEntry.sv
source/packetQueue.sv
source/serviceScheduler.sv
source/queueSchedTop.sv
tb/schedChecker.sv
tb/tbTop.sv

/* source/packetEntry.sv */
`include "sched_macros.svh"

module packetEntry (
	input  logic                    CLOCK_50,
	input  logic                    rstN_i,
	input  logic                    btnStartN_i,
	input  logic                    btnZeroN_i,
	input  logic                    btnOneN_i,
	output logic [`QUEUE_COUNT-1:0] pushOneHot_o,
	output schedPkg::payload_t      pushPayload_o
);
	import schedPkg::*;

	localparam int CountBits = $clog2(`CODE_BITS);

	entryState_t state;
	logic [CountBits-1:0] bitCount;
	logic [`CODE_BITS-1:0] codeShift;
	packet_t nextCode;

	logic zeroPress;
	logic onePress;
	logic validPress;
	logic bothReleased;
	logic lastBit;
	logic bitTaken;
	logic codeDone;

	// buttons are active low
	// a press counts only with the other button up
	assign zeroPress = !btnZeroN_i && btnOneN_i;
	assign onePress = !btnOneN_i && btnZeroN_i;
	assign validPress = zeroPress || onePress;
	// both up re-arms the next bit
	assign bothReleased = btnZeroN_i && btnOneN_i;

	assign lastBit = (bitCount == CountBits'(`CODE_BITS - 1));
	assign bitTaken = (state == ENTRY_WAIT_PRESS) && validPress;
	assign codeDone = bitTaken && lastBit;

	// code as it stands once the current bit is in
	// older presses move up toward the msb
	assign nextCode = packet_t'({codeShift[`CODE_BITS-2:0], onePress});

	// entry fsm
	always_ff @(posedge CLOCK_50) begin
		if (!rstN_i) begin
			state <= ENTRY_IDLE;
			bitCount <= '0;
		end else begin
			case (state)
				ENTRY_IDLE: begin
					// start press arms a new code
					if (!btnStartN_i) begin
						state <= ENTRY_WAIT_PRESS;
						bitCount <= '0;
					end
				end
				ENTRY_WAIT_PRESS: begin
					if (validPress) begin
						// counter wraps back to 0 after the last bit
						bitCount <= bitCount + 1'b1;
						if (lastBit) begin
							state <= ENTRY_IDLE;
						end else begin
							state <= ENTRY_WAIT_RELEASE;
						end
					end
				end
				ENTRY_WAIT_RELEASE: begin
					if (bothReleased) begin
						state <= ENTRY_WAIT_PRESS;
					end
				end
				default: begin
					state <= ENTRY_IDLE;
				end
			endcase
		end
	end

	// code shift register
	always_ff @(posedge CLOCK_50) begin
		if (bitTaken) begin
			codeShift <= nextCode;
		end
	end

	// one cycle push strobe, one-hot on the queue field
	always_ff @(posedge CLOCK_50) begin
		if (!rstN_i) begin
			pushOneHot_o <= '0;
		end else begin
			pushOneHot_o <= '0;
			if (codeDone) begin
				pushOneHot_o[nextCode.queue] <= 1'b1;
			end
		end
	end

	// payload rides alongside the strobe
	always_ff @(posedge CLOCK_50) begin
		if (codeDone) begin
			pushPayload_o <= nextCode.payload;
		end
	end

endmodule

/* source/packetQueue.sv */
`include "sched_macros.svh"

module packetQueue #(
	parameter int latencyWeight = 1,
	parameter int reliabilityWeight = 1
) (
	input  logic                 CLOCK_50,
	input  logic                 rstN_i,
	input  logic                 push_i,
	input  schedPkg::payload_t   pushPayload_i,
	input  logic                 pop_i,
	output schedPkg::payload_t   head_o,
	output schedPkg::occupancy_t occupancy_o,
	output schedPkg::score_t     score_o
);
	import schedPkg::*;

	// slot 0 holds the oldest entry
	payload_t slot [`QUEUE_DEPTH];

	occupancy_t count;
	occupancy_t countNext;
	occupancy_t writeIdx;
	score_t score;

	logic full;
	logic pushOk;
	logic popOk;

	// low fill favours latency, high fill favours reliability
	function automatic score_t weighScore(input occupancy_t occ);
		int fill;
		int raw;
		fill = int'(occ);
		if (fill == 0) begin
			raw = 0;
		end else if (fill <= `SIZE_KNEE) begin
			raw = fill * latencyWeight + reliabilityWeight;
		end else begin
			raw = fill * reliabilityWeight + latencyWeight;
		end
		return score_t'(raw);
	endfunction

	assign full = (count == occupancy_t'(`QUEUE_DEPTH));
	// push to a full queue is dropped
	assign pushOk = push_i && !full;
	// pop on empty does nothing
	assign popOk = pop_i && (count != '0);

	// on a joint pop the new entry lands one slot lower
	assign writeIdx = popOk ? count - 1'b1 : count;

	always_comb begin
		case ({pushOk, popOk})
			2'b10: countNext = count + 1'b1;
			2'b01: countNext = count - 1'b1;
			default: countNext = count;
		endcase
	end

	// count and score move together
	// score follows the new count so both match every cycle
	always_ff @(posedge CLOCK_50) begin
		if (!rstN_i) begin
			count <= '0;
			score <= '0;
		end else begin
			count <= countNext;
			score <= weighScore(countNext);
		end
	end

	// shift storage
	// the push write comes last and wins its slot
	always_ff @(posedge CLOCK_50) begin
		if (popOk) begin
			for (int i = 0; i < `QUEUE_DEPTH - 1; i++) begin
				slot[i] <= slot[i+1];
			end
		end
		if (pushOk) begin
			slot[writeIdx] <= pushPayload_i;
		end
	end

	assign head_o = slot[0];
	assign occupancy_o = count;
	assign score_o = score;

endmodule

/* source/queueSchedTop.sv */
`include "sched_macros.svh"

module queueSchedTop (
	input  logic                     CLOCK_50,
	input  logic                     rstN_i,
	input  logic                     btnStartN_i,
	input  logic                     btnZeroN_i,
	input  logic                     btnOneN_i,
	output schedPkg::occupancyVec_t  occupancy_o,
	output schedPkg::serviceRecord_t served_o,
	output logic                     servedValid_o
);
	import schedPkg::*;

	// entry to queues
	logic [`QUEUE_COUNT-1:0] pushOneHot;
	payload_t pushPayload;

	// scheduler to queues and back
	logic [`QUEUE_COUNT-1:0] popOneHot;
	payload_t [`QUEUE_COUNT-1:0] heads;
	scoreVec_t scores;

	// button decoder
	packetEntry entry0 (
		.CLOCK_50      (CLOCK_50),
		.rstN_i        (rstN_i),
		.btnStartN_i   (btnStartN_i),
		.btnZeroN_i    (btnZeroN_i),
		.btnOneN_i     (btnOneN_i),
		.pushOneHot_o  (pushOneHot),
		.pushPayload_o (pushPayload)
	);

	// queue 0 is the most latency bound, queue 3 the most reliability bound
	genvar q;
	generate
		for (q = 0; q < `QUEUE_COUNT; q++) begin : genQueue
			packetQueue #(
				.latencyWeight     (`LATENCY_WEIGHT_BASE - q),
				.reliabilityWeight (`RELIABILITY_BASE + q)
			) queueInst (
				.CLOCK_50      (CLOCK_50),
				.rstN_i        (rstN_i),
				.push_i        (pushOneHot[q]),
				.pushPayload_i (pushPayload),
				.pop_i         (popOneHot[q]),
				.head_o        (heads[q]),
				.occupancy_o   (occupancy_o[q]),
				.score_o       (scores[q])
			);
		end
	endgenerate

	// periodic service
	serviceScheduler sched0 (
		.CLOCK_50      (CLOCK_50),
		.rstN_i        (rstN_i),
		.occupancy_i   (occupancy_o),
		.score_i       (scores),
		.heads_i       (heads),
		.popOneHot_o   (popOneHot),
		.served_o      (served_o),
		.servedValid_o (servedValid_o)
	);

endmodule

/* source/schedPkg.sv */
`include "sched_macros.svh"

package schedPkg;

	// queue number, first two presses of a code
	typedef logic [`QUEUE_IDX_BITS-1:0] queueIdx_t;

	// payload, last two presses of a code
	typedef logic [`PAYLOAD_BITS-1:0] payload_t;

	// entries held by one queue, 0 to depth
	typedef logic [`OCCUPANCY_BITS-1:0] occupancy_t;

	// weighted backlog of one queue
	typedef logic [`SCORE_BITS-1:0] score_t;

	// one entered code
	// first press lands in the msb
	typedef struct packed {
		queueIdx_t queue;
		payload_t  payload;
	} packet_t;

	// one served packet
	typedef struct packed {
		queueIdx_t queue;
		payload_t  payload;
	} serviceRecord_t;

	// per queue status, index = queue number
	typedef occupancy_t [`QUEUE_COUNT-1:0] occupancyVec_t;
	typedef score_t [`QUEUE_COUNT-1:0] scoreVec_t;

	// button entry fsm
	typedef enum logic [1:0] {
		ENTRY_IDLE,
		ENTRY_WAIT_PRESS,
		ENTRY_WAIT_RELEASE
	} entryState_t;

endpackage

/* source/sched_macros.svh */
`ifndef SCHED_MACROS_SVH
`define SCHED_MACROS_SVH

// queue count and depth
`define QUEUE_COUNT 4
`define QUEUE_DEPTH 6

// clock cycles between two service ticks
`define SERVICE_PERIOD 60

// occupancy at or below this is scored latency first
`define SIZE_KNEE 3

// button presses per packet code
`define CODE_BITS 4

// field widths
`define QUEUE_IDX_BITS 2
`define PAYLOAD_BITS 2
`define OCCUPANCY_BITS 3
// max score is 6*4+1 on the last queue
`define SCORE_BITS 5

// queue i gets latency weight base-i
`define LATENCY_WEIGHT_BASE `QUEUE_COUNT
// queue i gets reliability weight base+i
`define RELIABILITY_BASE 1

`endif

/* source/serviceScheduler.sv */
`include "sched_macros.svh"

module serviceScheduler (
	input  logic                                  CLOCK_50,
	input  logic                                  rstN_i,
	input  schedPkg::occupancyVec_t               occupancy_i,
	input  schedPkg::scoreVec_t                   score_i,
	input  schedPkg::payload_t [`QUEUE_COUNT-1:0] heads_i,
	output logic [`QUEUE_COUNT-1:0]               popOneHot_o,
	output schedPkg::serviceRecord_t              served_o,
	output logic                                  servedValid_o
);
	import schedPkg::*;

	localparam int PeriodBits = $clog2(`SERVICE_PERIOD);

	logic [PeriodBits-1:0] periodCount;
	logic tick;

	// winner of the current cycle
	logic anyReady;
	queueIdx_t bestIdx;
	score_t bestScore;

	logic serve;

	// service period counter
	// first tick lands SERVICE_PERIOD cycles after reset release
	assign tick = (periodCount == PeriodBits'(`SERVICE_PERIOD - 1));

	always_ff @(posedge CLOCK_50) begin
		if (!rstN_i) begin
			periodCount <= '0;
		end else if (tick) begin
			periodCount <= '0;
		end else begin
			periodCount <= periodCount + 1'b1;
		end
	end

	// max score among nonempty queues
	// strict compare keeps the lowest index on a tie
	always_comb begin
		anyReady = 1'b0;
		bestIdx = '0;
		bestScore = '0;
		for (int i = 0; i < `QUEUE_COUNT; i++) begin
			if ((occupancy_i[i] != '0) && (!anyReady || (score_i[i] > bestScore))) begin
				anyReady = 1'b1;
				bestIdx = queueIdx_t'(i);
				bestScore = score_i[i];
			end
		end
	end

	assign serve = tick && anyReady;

	// pop leaves in the tick cycle
	// queue count then drops in the same cycle servedValid_o rises
	always_comb begin
		popOneHot_o = '0;
		if (serve) begin
			popOneHot_o[bestIdx] = 1'b1;
		end
	end

	// service valid strobe
	always_ff @(posedge CLOCK_50) begin
		if (!rstN_i) begin
			servedValid_o <= 1'b0;
		end else begin
			servedValid_o <= serve;
		end
	end

	// head is captured before the pop shifts it out
	always_ff @(posedge CLOCK_50) begin
		if (serve) begin
			served_o.queue <= bestIdx;
			served_o.payload <= heads_i[bestIdx];
		end
	end

endmodule

/* tb/schedChecker.sv */
`include "sched_macros.svh"

module schedChecker (
	input  logic                     CLOCK_50,
	input  logic                     rstN_i,
	input  logic                     btnStartN_i,
	input  logic                     btnZeroN_i,
	input  logic                     btnOneN_i,
	input  schedPkg::occupancyVec_t  occupancy_i,
	input  schedPkg::serviceRecord_t served_i,
	input  logic                     servedValid_i,
	output int                       errorCount_o,
	output int                       checkCount_o,
	output int                       dropCount_o,
	output int                       serveCount_o
);
	import schedPkg::*;

	localparam int EntryIdle = 0;
	localparam int EntryPress = 1;
	localparam int EntryRelease = 2;

	int errors = 0;
	int checks = 0;
	int drops = 0;
	int serves = 0;

	// button decoder model
	int entryState = EntryIdle;
	int bitCount = 0;
	int code = 0;

	// predicted pushes, press sample to occupancy takes two samples
	logic pushNear = 1'b0;
	logic pushFar = 1'b0;
	int codeNear = 0;
	int codeFar = 0;

	// service model
	int periodCount = 0;
	logic expectServe = 1'b0;
	int expectQueue = 0;

	occupancyVec_t prevOcc;
	logic resetSeen = 1'b0;
	// payloads in entry order, one FIFO per queue
	payload_t modelFifo [`QUEUE_COUNT][$];

	assign errorCount_o = errors;
	assign checkCount_o = checks;
	assign dropCount_o = drops;
	assign serveCount_o = serves;

	// latency weight falls with the index, reliability weight rises
	function automatic int queueScore(input int q, input int occ);
		int lat;
		int rel;
		lat = `LATENCY_WEIGHT_BASE - q;
		rel = `RELIABILITY_BASE + q;
		if (occ == 0) begin
			return 0;
		end
		if (occ <= `SIZE_KNEE) begin
			return occ * lat + rel;
		end
		return occ * rel + lat;
	endfunction

	// highest score among nonempty queues, -1 when all are empty
	function automatic int pickQueue(input occupancyVec_t occ);
		int best;
		int bestScore;
		int s;
		best = -1;
		bestScore = -1;
		for (int q = 0; q < `QUEUE_COUNT; q++) begin
			s = queueScore(q, int'(occ[queueIdx_t'(q)]));
			// strictly greater, so a tie stays with the lower index
			if ((occ[queueIdx_t'(q)] != '0) && (s > bestScore)) begin
				best = q;
				bestScore = s;
			end
		end
		return best;
	endfunction

	task automatic expectEqual(input string what, input int got, input int expected);
		checks++;
		if (got != expected) begin
			errors++;
			$display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, expected);
		end
	endtask

	// inputs were driven on the falling edge, outputs read before the update
	always @(posedge CLOCK_50) begin : sampleBlock
		logic zeroPress;
		logic onePress;
		logic newCode;
		logic tickNow;
		int expOcc;
		payload_t front;
		if (!rstN_i) begin
			// registers have seen one reset edge by now
			if (resetSeen) begin
				expectEqual("servedValid_o in reset", int'(servedValid_i), 0);
				for (int q = 0; q < `QUEUE_COUNT; q++) begin
					expectEqual($sformatf("queue %0d occupancy in reset", q),
						int'(occupancy_i[queueIdx_t'(q)]), 0);
				end
			end
			resetSeen = 1'b1;
			entryState = EntryIdle;
			bitCount = 0;
			pushNear = 1'b0;
			pushFar = 1'b0;
			periodCount = 0;
			expectServe = 1'b0;
			for (int q = 0; q < `QUEUE_COUNT; q++) begin
				modelFifo[queueIdx_t'(q)].delete();
			end
		end else begin
			// service decided at the previous sample
			expectEqual("servedValid_o", int'(servedValid_i), int'(expectServe));
			if (expectServe && servedValid_i) begin
				serves++;
				expectEqual("served queue", int'(served_i.queue), expectQueue);
				if (modelFifo[queueIdx_t'(expectQueue)].size() == 0) begin
					errors++;
					$display("error at %0t: queue %0d was served but holds no packet in the model",
						$time, expectQueue);
				end else begin
					front = modelFifo[queueIdx_t'(expectQueue)].pop_front();
					expectEqual("served payload", int'(served_i.payload), int'(front));
				end
			end
			// pop of this service, push from two samples back
			for (int q = 0; q < `QUEUE_COUNT; q++) begin
				expOcc = int'(prevOcc[queueIdx_t'(q)]);
				if (expectServe && (expectQueue == q)) begin
					expOcc--;
				end
				if (pushFar && ((codeFar >> 2) == q)) begin
					// full before the edge means the packet is lost
					if (int'(prevOcc[queueIdx_t'(q)]) < `QUEUE_DEPTH) begin
						expOcc++;
						modelFifo[queueIdx_t'(q)].push_back(payload_t'(codeFar & 3));
					end else begin
						drops++;
					end
				end
				expectEqual($sformatf("queue %0d occupancy", q),
					int'(occupancy_i[queueIdx_t'(q)]), expOcc);
			end
			pushFar = pushNear;
			codeFar = codeNear;

			// one press at a time, both up before the next bit
			zeroPress = !btnZeroN_i && btnOneN_i;
			onePress = !btnOneN_i && btnZeroN_i;
			newCode = 1'b0;
			case (entryState)
				EntryIdle: begin
					if (!btnStartN_i) begin
						entryState = EntryPress;
						bitCount = 0;
					end
				end
				EntryPress: begin
					if (zeroPress || onePress) begin
						code = ((code << 1) | int'(onePress)) & ((1 << `CODE_BITS) - 1);
						if (bitCount == `CODE_BITS - 1) begin
							newCode = 1'b1;
							entryState = EntryIdle;
						end else begin
							bitCount++;
							entryState = EntryRelease;
						end
					end
				end
				EntryRelease: begin
					if (btnZeroN_i && btnOneN_i) begin
						entryState = EntryPress;
					end
				end
				default: begin
					entryState = EntryIdle;
				end
			endcase
			pushNear = newCode;
			codeNear = code;

			// tick every service period after reset release
			tickNow = (periodCount == `SERVICE_PERIOD - 1);
			periodCount = tickNow ? 0 : periodCount + 1;
			expectQueue = pickQueue(occupancy_i);
			expectServe = tickNow && (expectQueue >= 0);
		end
		prevOcc = occupancy_i;
	end

endmodule

/* tb/tbTop.sv */
`include "sched_macros.svh"

module tbTop;
	import schedPkg::*;

	localparam int ResetCycles = 10;
	localparam int RandomPackets = 24;
	localparam int BurstPackets = 14;
	// start, four press and release pairs, longest random gap
	localparam int PacketCycles = 1 + `CODE_BITS * 4 + 7;
	// every slot of every queue served once, plus slack
	localparam int DrainCycles = (`QUEUE_COUNT * `QUEUE_DEPTH + 2) * `SERVICE_PERIOD;
	localparam int WatchdogCycles = ResetCycles + 40
		+ (RandomPackets + BurstPackets + 2) * PacketCycles * 2 + DrainCycles;

	logic CLOCK_50 = 1'b0;
	logic rstN;
	logic btnStartN;
	logic btnZeroN;
	logic btnOneN;
	occupancyVec_t occupancy;
	serviceRecord_t served;
	logic servedValid;

	logic [31:0] lfsrState = 32'h35ce;
	int errorCount;
	int checkCount;
	int dropCount;
	int serveCount;
	int tbErrors = 0;
	int q;
	int p;
	int gap;

	always #10 CLOCK_50 = !CLOCK_50;

	queueSchedTop dut0 (
		.CLOCK_50      (CLOCK_50),
		.rstN_i        (rstN),
		.btnStartN_i   (btnStartN),
		.btnZeroN_i    (btnZeroN),
		.btnOneN_i     (btnOneN),
		.occupancy_o   (occupancy),
		.served_o      (served),
		.servedValid_o (servedValid)
	);

	schedChecker chk0 (
		.CLOCK_50      (CLOCK_50),
		.rstN_i        (rstN),
		.btnStartN_i   (btnStartN),
		.btnZeroN_i    (btnZeroN),
		.btnOneN_i     (btnOneN),
		.occupancy_i   (occupancy),
		.served_i      (served),
		.servedValid_i (servedValid),
		.errorCount_o  (errorCount),
		.checkCount_o  (checkCount),
		.dropCount_o   (dropCount),
		.serveCount_o  (serveCount)
	);

	// fibonacci, taps 32 22 2 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic takeBits(input int n, output int value);
		value = 0;
		repeat (n) begin
			lfsrState = lfsrStep(lfsrState);
			value = (value << 1) | int'(lfsrState[0]);
		end
	endtask

	// set on a falling edge, held for the given cycles
	task automatic holdButtons(input logic startN, input logic zeroN, input logic oneN,
		input int cycles);
		@(negedge CLOCK_50);
		btnStartN = startN;
		btnZeroN = zeroN;
		btnOneN = oneN;
		repeat (cycles - 1) @(negedge CLOCK_50);
	endtask

	// press then release, two cycles each
	task automatic pressBit(input logic b);
		holdButtons(1'b1, b, !b, 2);
		holdButtons(1'b1, 1'b1, 1'b1, 2);
	endtask

	task automatic sendPacket(input int queue, input int payload, input int idle);
		int code;
		code = queue * 4 + payload;
		holdButtons(1'b0, 1'b1, 1'b1, 1);
		// queue bits first, msb first
		for (int i = `CODE_BITS - 1; i >= 0; i--) begin
			pressBit(((code >> i) & 1) == 1);
		end
		if (idle > 0) begin
			holdButtons(1'b1, 1'b1, 1'b1, idle);
		end
	endtask

	task automatic strayPresses();
		// no start yet, so ignored
		pressBit(1'b0);
		pressBit(1'b1);
		holdButtons(1'b0, 1'b1, 1'b1, 1);
		pressBit(1'b1);
		// both held is not a bit
		holdButtons(1'b1, 1'b0, 1'b0, 3);
		holdButtons(1'b1, 1'b1, 1'b1, 2);
		pressBit(1'b0);
		pressBit(1'b1);
		pressBit(1'b0);
	endtask

	initial begin
		rstN = 1'b0;
		btnStartN = 1'b1;
		btnZeroN = 1'b1;
		btnOneN = 1'b1;
		repeat (ResetCycles) @(negedge CLOCK_50);
		rstN = 1'b1;
		holdButtons(1'b1, 1'b1, 1'b1, 20);
		strayPresses();
		for (int k = 0; k < RandomPackets; k++) begin
			takeBits(2, q);
			takeBits(2, p);
			takeBits(3, gap);
			sendPacket(q, p, gap);
		end
		// back to back into queue 1, faster than the service rate
		for (int k = 0; k < BurstPackets; k++) begin
			sendPacket(1, k % 4, 0);
		end
		holdButtons(1'b1, 1'b1, 1'b1, DrainCycles);
		if (dropCount == 0) begin
			tbErrors++;
			$display("error: the burst into queue 1 dropped no packet");
		end
		if (serveCount == 0) begin
			tbErrors++;
			$display("error: no packet was ever served");
		end
		if (occupancy != '0) begin
			tbErrors++;
			$display("error: queues still hold packets after the drain");
		end
		$display("checks %0d, errors %0d, drops %0d, services %0d",
			checkCount, errorCount + tbErrors, dropCount, serveCount);
		if (errorCount + tbErrors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// run length bound from packet count and drain time
	initial begin
		repeat (WatchdogCycles) @(posedge CLOCK_50);
		$display("timeout: the run did not finish within %0d cycles", WatchdogCycles);
		$display("Some tests failed");
		$finish;
	end

endmodule
